// File: list.f
bp_pkg.sv
sat_counter_table.sv
local_history_table.sv
btb.sv
perf_counter.sv
resolve_unit.sv
branch_predictor.sv
bp_checker.sv
bp_assert.sv
tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - bp_pkg.sv
  - sat_counter_table.sv
  - local_history_table.sv
  - btb.sv
  - perf_counter.sv
  - resolve_unit.sv
  - branch_predictor.sv
  - target: simulation
    files:
      - bp_checker.sv
      - bp_assert.sv
      - tb_branch_predictor.sv

// File: tb_branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module tb_branch_predictor
    import bp_pkg::*;
();

    logic                  clk;
    logic                  rst;
    logic                  lookup_en;
    word_t                 lookup_pc;
    logic                  resolve_en;
    logic                  resolve_taken;
    word_t                 resolve_target;
    branch_kind_t          resolve_kind;
    logic                  pred_hit;
    logic                  pred_taken;
    word_t                 pred_target;
    logic                  mispredict;
    logic [PERF_WIDTH-1:0] ctrl_count;
    logic [PERF_WIDTH-1:0] no_stall_count;
    logic [PERF_WIDTH-1:0] correct_count;
    logic                  ctrl_overflow;
    logic                  no_stall_overflow;
    logic                  correct_overflow;
    int                    error_count;
    int                    check_count;

    logic [31:0] seed;
    int          errors_before;
    int          tests_done;
    logic        timed_out;

    branch_predictor dut_i (.*);

    bp_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = lcg_next(seed);
        r    = seed;
    endtask

    task automatic drive(input logic l_en, input word_t pc, input logic r_en,
                         input logic taken, input word_t target, input branch_kind_t kind);
        @(posedge clk);
        lookup_en      <= l_en;
        lookup_pc      <= pc;
        resolve_en     <= r_en;
        resolve_taken  <= taken;
        resolve_target <= target;
        resolve_kind   <= kind;
    endtask

    // idle a cycle, then wait for the checker to compare it
    task automatic finish_test(input string name);
        int start;
        int cycles;
        drive(1'b0, '0, 1'b0, 1'b0, '0, kind_br);
        start  = check_count;
        cycles = 0;
        while (check_count < start + 2 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (check_count < start + 2) begin
            $display("timeout in %s: checker stopped comparing", name);
            timed_out = 1'b1;
        end
        tests_done++;
        $display("test %s: %0d errors", name, error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin
        logic [31:0] r;
        word_t       prev_pc;
        logic        prev_valid;
        logic        prev_taken;
        int          seen [4];
        int          idx;
        branch_kind_t kind;
        seed = 32'h5f2019c6;
        rst = 1'b1;
        lookup_en = 1'b0;
        lookup_pc = '0;
        resolve_en = 1'b0;
        resolve_taken = 1'b0;
        resolve_target = '0;
        resolve_kind = kind_br;
        errors_before = 0;
        tests_done = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // empty btb, lookups only
        for (int i = 0; i < 16; i++) begin
            next_rand(r);
            drive(1'b1, {r[31:2], 2'b00}, 1'b0, 1'b0, '0, kind_br);
        end
        finish_test("reset");

        drive(1'b1, 32'h100, 1'b0, 1'b0, '0, kind_br);
        drive(1'b0, '0, 1'b1, 1'b1, 32'h2000, kind_jal);
        drive(1'b1, 32'h100, 1'b0, 1'b0, '0, kind_br);
        drive(1'b1, 32'h204, 1'b0, 1'b0, '0, kind_br);
        drive(1'b0, '0, 1'b1, 1'b1, 32'h3001, kind_jalr); // odd target
        drive(1'b1, 32'h204, 1'b0, 1'b0, '0, kind_br);
        finish_test("jumps");

        // 0x140 shares btb index 0 with 0x100
        drive(1'b1, 32'h140, 1'b0, 1'b0, '0, kind_br);
        drive(1'b0, '0, 1'b1, 1'b1, 32'h4000, kind_jal);
        drive(1'b1, 32'h140, 1'b0, 1'b0, '0, kind_br);
        drive(1'b1, 32'h100, 1'b0, 1'b0, '0, kind_br);
        finish_test("evict");

        // branch streams over four pcs with different patterns
        prev_valid = 1'b0;
        prev_taken = 1'b0;
        prev_pc    = '0;
        seen       = '{default: 0};
        for (int i = 0; i < 240; i++) begin
            next_rand(r);
            idx = r[17:16];
            drive(1'b1, 32'h400 + idx * 8, prev_valid, prev_taken, prev_pc + 32'h40, kind_br);
            prev_pc = 32'h400 + idx * 8;
            case (idx)
                0:       prev_taken = 1'b1;
                1:       prev_taken = seen[1][0];      // alternating
                2:       prev_taken = r[24];
                default: prev_taken = (seen[3] % 4) != 3; // loop of four
            endcase
            seen[idx]++;
            prev_valid = 1'b1;
        end
        drive(1'b0, '0, 1'b1, prev_taken, prev_pc + 32'h40, kind_br);
        finish_test("branches");

        // mixed lookups and resolves with aliasing pcs
        for (int i = 0; i < 300; i++) begin
            next_rand(r);
            kind = (r[19:18] == 2'd3) ? kind_br : branch_kind_t'(r[19:18]);
            drive(r[16] | r[17], 32'h800 + (r[12:8] << 2) + (r[13] ? 32'h40 : 32'h0),
                  r[14] | r[15], (kind != kind_br) || r[20],
                  32'h1000 + (r[23:21] << 3) + r[24], kind);
        end
        finish_test("mixed");

        $display("summary: %0d tests, %0d checks, %0d errors", tests_done, check_count,
                 error_count);
        if (timed_out || error_count != 0) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule : tb_branch_predictor

`default_nettype wire

// File: bp_assert.sv
`timescale 1ns/100ps
`default_nettype none

module bp_assert
    import bp_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  resolve_en,
    input logic                  mispredict,
    input logic                  pred_hit,
    input logic                  pred_taken,
    input logic [PERF_WIDTH-1:0] ctrl_count,
    input logic [PERF_WIDTH-1:0] no_stall_count,
    input logic [PERF_WIDTH-1:0] correct_count
);

    property count_step(logic [PERF_WIDTH-1:0] c);
        @(posedge clk) disable iff (rst) PERF_WIDTH'(c - $past(c)) <= 1; // wrap counts as one
    endproperty

    misp_needs_resolve: assert property (@(posedge clk) disable iff (rst)
        mispredict |-> resolve_en) else $error("mispredict without resolve_en");

    taken_needs_hit: assert property (@(posedge clk) disable iff (rst)
        pred_taken |-> pred_hit) else $error("pred_taken without pred_hit");

    ctrl_step: assert property (count_step(ctrl_count))
        else $error("ctrl_count moved by more than one");
    no_stall_step: assert property (count_step(no_stall_count))
        else $error("no_stall_count moved by more than one");
    correct_step: assert property (count_step(correct_count))
        else $error("correct_count moved by more than one");

endmodule : bp_assert

bind branch_predictor bp_assert assert_i (
    .clk            (clk),
    .rst            (rst),
    .resolve_en     (resolve_en),
    .mispredict     (mispredict),
    .pred_hit       (pred_hit),
    .pred_taken     (pred_taken),
    .ctrl_count     (ctrl_count),
    .no_stall_count (no_stall_count),
    .correct_count  (correct_count)
);

`default_nettype wire

// File: bp_checker.sv
`timescale 1ns/100ps
`default_nettype none

module bp_checker
    import bp_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lookup_en,
    input  word_t                 lookup_pc,
    input  logic                  resolve_en,
    input  logic                  resolve_taken,
    input  word_t                 resolve_target,
    input  branch_kind_t          resolve_kind,
    input  logic                  pred_hit,
    input  logic                  pred_taken,
    input  word_t                 pred_target,
    input  logic                  mispredict,
    input  logic [PERF_WIDTH-1:0] ctrl_count,
    input  logic [PERF_WIDTH-1:0] no_stall_count,
    input  logic [PERF_WIDTH-1:0] correct_count,
    input  logic                  ctrl_overflow,
    input  logic                  no_stall_overflow,
    input  logic                  correct_overflow,
    output int                    error_count,
    output int                    check_count
);

    // model of the tables
    logic                       m_btb_valid  [2**BTB_INDEX_BITS];
    logic [31:BTB_INDEX_BITS+2] m_btb_tag    [2**BTB_INDEX_BITS];
    word_t                      m_btb_target [2**BTB_INDEX_BITS];
    branch_kind_t               m_btb_kind   [2**BTB_INDEX_BITS];
    logic [1:0]                 m_gpht       [2**HIST_BITS];
    logic [1:0]                 m_lpht       [2**HIST_BITS];
    logic [1:0]                 m_chooser    [2**CHOOSER_INDEX_BITS];
    logic [HIST_BITS-1:0]       m_lhist      [2**BHT_INDEX_BITS];
    logic [HIST_BITS-1:0]       m_ghr;

    // model of the lookup record
    word_t                r_pc;
    logic [HIST_BITS-1:0] r_gidx;
    logic [HIST_BITS-1:0] r_lidx;
    logic                 r_gpr;
    logic                 r_lpr;
    logic                 r_taken;
    word_t                r_target;

    logic [PERF_WIDTH-1:0] m_ctrl;
    logic [PERF_WIDTH-1:0] m_no_stall;
    logic [PERF_WIDTH-1:0] m_correct;
    logic                  m_ctrl_ovf;
    logic                  m_no_stall_ovf;
    logic                  m_correct_ovf;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    // expected {hit, taken, target} from the model before this edge's updates
    function automatic logic [33:0] predict_expected(input word_t pc);
        logic [BTB_INDEX_BITS-1:0] bi;
        logic                      hit;
        logic                      dir;
        logic                      taken;
        bi  = pc[BTB_INDEX_BITS+1:2];
        hit = m_btb_valid[bi] && (m_btb_tag[bi] == pc[31:BTB_INDEX_BITS+2]);
        if (m_chooser[pc[CHOOSER_INDEX_BITS+1:2]] >= 2'd2) begin
            dir = m_gpht[m_ghr][1];
        end else begin
            dir = m_lpht[m_lhist[pc[BHT_INDEX_BITS+1:2]]][1];
        end
        taken = hit && ((m_btb_kind[bi] != kind_br) || dir);
        return {hit, taken, (hit ? m_btb_target[bi] : 32'h0)};
    endfunction

    function automatic logic [1:0] step_ctr(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic bump(inout logic [PERF_WIDTH-1:0] v, inout logic ovf);
        if (&v) begin
            ovf = 1'b1; // wraps this time
        end
        v = v + 1'b1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h at %0t ns", name, got, exp, $time);
            error_count++;
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 2**BTB_INDEX_BITS; i++) begin
            m_btb_valid[i] = 1'b0;
        end
        for (int i = 0; i < 2**HIST_BITS; i++) begin
            m_gpht[i] = CTR_INIT;
            m_lpht[i] = CTR_INIT;
        end
        for (int i = 0; i < 2**CHOOSER_INDEX_BITS; i++) begin
            m_chooser[i] = CTR_INIT;
        end
        for (int i = 0; i < 2**BHT_INDEX_BITS; i++) begin
            m_lhist[i] = '0;
        end
        m_ghr    = '0;
        r_pc     = '0;
        r_gidx   = '0;
        r_lidx   = '0;
        r_gpr    = 1'b0;
        r_lpr    = 1'b0;
        r_taken  = 1'b0;
        r_target = '0;
        {m_ctrl, m_no_stall, m_correct} = '0;
        {m_ctrl_ovf, m_no_stall_ovf, m_correct_ovf} = '0;
    endtask

    // inputs change on the rising edge, so the falling edge sees settled outputs
    always @(negedge clk) begin : compare
        logic [33:0]               exp;
        logic                      exp_misp;
        word_t                     eff;
        logic [HIST_BITS-1:0]      n_gidx;
        logic [HIST_BITS-1:0]      n_lidx;
        logic                      n_gpr;
        logic                      n_lpr;
        logic [BTB_INDEX_BITS-1:0] bi;
        logic [CHOOSER_INDEX_BITS-1:0] ci;
        if (rst !== 1'b0) begin
            reset_model();
        end else begin
            exp    = predict_expected(lookup_pc);
            n_gidx = m_ghr;
            n_lidx = m_lhist[lookup_pc[BHT_INDEX_BITS+1:2]];
            n_gpr  = m_gpht[n_gidx][1]; // read before this edge's training
            n_lpr  = m_lpht[n_lidx][1];
            if (lookup_en) begin
                check_value("pred_hit", pred_hit, exp[33]);
                check_value("pred_taken", pred_taken, exp[32]);
                if (exp[33]) begin
                    check_value("pred_target", pred_target, exp[31:0]);
                end
            end
            eff = (resolve_kind == kind_jalr) ? {resolve_target[31:1], 1'b0} : resolve_target;
            exp_misp = resolve_en && ((r_taken != resolve_taken) ||
                       (resolve_taken && (r_target != eff)));
            check_value("mispredict", mispredict, exp_misp);
            check_value("ctrl_count", ctrl_count, m_ctrl);
            check_value("no_stall_count", no_stall_count, m_no_stall);
            check_value("correct_count", correct_count, m_correct);
            check_value("ctrl_overflow", ctrl_overflow, m_ctrl_ovf);
            check_value("no_stall_overflow", no_stall_overflow, m_no_stall_ovf);
            check_value("correct_overflow", correct_overflow, m_correct_ovf);
            check_count++;

            // coming edge's updates use the old record
            if (resolve_en) begin
                if (resolve_taken) begin
                    bi = r_pc[BTB_INDEX_BITS+1:2];
                    m_btb_valid[bi]  = 1'b1;
                    m_btb_tag[bi]    = r_pc[31:BTB_INDEX_BITS+2];
                    m_btb_target[bi] = eff;
                    m_btb_kind[bi]   = resolve_kind;
                end
                if (resolve_kind == kind_br) begin
                    ci = r_pc[CHOOSER_INDEX_BITS+1:2];
                    m_ghr = {m_ghr[HIST_BITS-2:0], resolve_taken};
                    m_lhist[r_pc[BHT_INDEX_BITS+1:2]] =
                        {m_lhist[r_pc[BHT_INDEX_BITS+1:2]][HIST_BITS-2:0], resolve_taken};
                    m_gpht[r_gidx] = step_ctr(m_gpht[r_gidx], resolve_taken);
                    m_lpht[r_lidx] = step_ctr(m_lpht[r_lidx], resolve_taken);
                    if (r_gpr != r_lpr) begin
                        m_chooser[ci] = step_ctr(m_chooser[ci], r_gpr == resolve_taken);
                    end
                    if (r_taken == resolve_taken) begin
                        bump(m_correct, m_correct_ovf);
                    end
                end
                bump(m_ctrl, m_ctrl_ovf);
                if (!exp_misp) begin
                    bump(m_no_stall, m_no_stall_ovf);
                end
            end
            if (lookup_en) begin
                r_pc     = lookup_pc;
                r_gidx   = n_gidx;
                r_lidx   = n_lidx;
                r_gpr    = n_gpr;
                r_lpr    = n_lpr;
                r_taken  = exp[32];
                r_target = exp[31:0];
            end
        end
    end

endmodule : bp_checker

`default_nettype wire

// File: branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predictor
    import bp_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lookup_en,
    input  word_t                 lookup_pc,
    input  logic                  resolve_en,
    input  logic                  resolve_taken,
    input  word_t                 resolve_target,
    input  branch_kind_t          resolve_kind,
    output logic                  pred_hit,
    output logic                  pred_taken,
    output word_t                 pred_target,
    output logic                  mispredict,
    output logic [PERF_WIDTH-1:0] ctrl_count,
    output logic [PERF_WIDTH-1:0] no_stall_count,
    output logic [PERF_WIDTH-1:0] correct_count,
    output logic                  ctrl_overflow,
    output logic                  no_stall_overflow,
    output logic                  correct_overflow
);

    logic [HIST_BITS-1:0] ghr;
    logic [HIST_BITS-1:0] local_hist;
    logic                 global_pr;
    logic                 local_pr;
    logic                 use_global;
    logic                 chosen_pr;
    branch_kind_t         btb_kind;

    // lookup record, snapshot for training at resolve
    word_t                rec_pc;
    logic [HIST_BITS-1:0] rec_global_idx;
    logic [HIST_BITS-1:0] rec_local_idx;
    logic                 rec_global_pr;
    logic                 rec_local_pr;
    logic                 rec_hit;
    logic                 rec_taken;
    word_t                rec_target;

    logic  btb_write;
    word_t eff_target;
    logic  history_shift;
    logic  pht_inc;
    logic  pht_dec;
    logic  chooser_inc;
    logic  chooser_dec;
    logic  count_ctrl;
    logic  count_no_stall;
    logic  count_correct;

    btb u_btb (
        .clk          (clk),
        .rst          (rst),
        .read_pc      (lookup_pc),
        .write_en     (btb_write),
        .write_pc     (rec_pc),
        .write_target (eff_target),
        .write_kind   (resolve_kind),
        .hit          (pred_hit),
        .target       (pred_target),
        .kind         (btb_kind)
    );

    local_history_table u_bht (
        .clk      (clk),
        .rst      (rst),
        .read_pc  (lookup_pc),
        .write_en (history_shift),
        .write_pc (rec_pc),
        .taken    (resolve_taken),
        .history  (local_hist)
    );

    sat_counter_table #(.index_bits(HIST_BITS)) global_pht (
        .clk         (clk),
        .rst         (rst),
        .read_index  (ghr),
        .write_index (rec_global_idx),
        .inc         (pht_inc),
        .dec         (pht_dec),
        .prediction  (global_pr)
    );

    sat_counter_table #(.index_bits(HIST_BITS)) local_pht (
        .clk         (clk),
        .rst         (rst),
        .read_index  (local_hist),
        .write_index (rec_local_idx),
        .inc         (pht_inc),
        .dec         (pht_dec),
        .prediction  (local_pr)
    );

    sat_counter_table #(.index_bits(CHOOSER_INDEX_BITS)) chooser (
        .clk         (clk),
        .rst         (rst),
        .read_index  (lookup_pc[CHOOSER_INDEX_BITS+1:2]),
        .write_index (rec_pc[CHOOSER_INDEX_BITS+1:2]),
        .inc         (chooser_inc),
        .dec         (chooser_dec),
        .prediction  (use_global) // counter >= 2 picks global
    );

    assign chosen_pr  = use_global ? global_pr : local_pr;
    assign pred_taken = pred_hit && ((btb_kind != kind_br) || chosen_pr); // jumps always taken

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (history_shift) begin
            ghr <= {ghr[HIST_BITS-2:0], resolve_taken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_pc         <= '0;
            rec_global_idx <= '0;
            rec_local_idx  <= '0;
            rec_global_pr  <= 1'b0;
            rec_local_pr   <= 1'b0;
            rec_hit        <= 1'b0;
            rec_taken      <= 1'b0;
            rec_target     <= '0;
        end else if (lookup_en) begin
            rec_pc         <= lookup_pc;
            rec_global_idx <= ghr;        // pre-update history
            rec_local_idx  <= local_hist;
            rec_global_pr  <= global_pr;
            rec_local_pr   <= local_pr;
            rec_hit        <= pred_hit;
            rec_taken      <= pred_taken;
            rec_target     <= pred_target;
        end
    end

    resolve_unit u_resolve (
        .resolve_en     (resolve_en),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .resolve_kind   (resolve_kind),
        .rec_hit        (rec_hit),
        .rec_taken      (rec_taken),
        .rec_target     (rec_target),
        .rec_local_pr   (rec_local_pr),
        .rec_global_pr  (rec_global_pr),
        .mispredict     (mispredict),
        .btb_write      (btb_write),
        .eff_target     (eff_target),
        .history_shift  (history_shift),
        .pht_inc        (pht_inc),
        .pht_dec        (pht_dec),
        .chooser_inc    (chooser_inc),
        .chooser_dec    (chooser_dec),
        .count_ctrl     (count_ctrl),
        .count_no_stall (count_no_stall),
        .count_correct  (count_correct)
    );

    perf_counter u_ctrl_cnt (
        .clk      (clk),
        .rst      (rst),
        .count    (count_ctrl),
        .value    (ctrl_count),
        .overflow (ctrl_overflow)
    );

    perf_counter u_no_stall_cnt (
        .clk      (clk),
        .rst      (rst),
        .count    (count_no_stall),
        .value    (no_stall_count),
        .overflow (no_stall_overflow)
    );

    perf_counter u_correct_cnt (
        .clk      (clk),
        .rst      (rst),
        .count    (count_correct),
        .value    (correct_count),
        .overflow (correct_overflow)
    );

endmodule : branch_predictor

`default_nettype wire

// File: resolve_unit.sv
`timescale 1ns/100ps
`default_nettype none

module resolve_unit
    import bp_pkg::*;
(
    input  logic         resolve_en,
    input  logic         resolve_taken,
    input  word_t        resolve_target,
    input  branch_kind_t resolve_kind,
    input  logic         rec_hit,
    input  logic         rec_taken,
    input  word_t        rec_target,
    input  logic         rec_local_pr,
    input  logic         rec_global_pr,
    output logic         mispredict,
    output logic         btb_write,
    output word_t        eff_target,
    output logic         history_shift,
    output logic         pht_inc,
    output logic         pht_dec,
    output logic         chooser_inc,
    output logic         chooser_dec,
    output logic         count_ctrl,
    output logic         count_no_stall,
    output logic         count_correct
);

    logic is_br;
    logic wrong_dir;
    logic wrong_target;
    logic pr_differ;
    logic global_right;

    // jalr target has bit 0 cleared
    assign eff_target = (resolve_kind == kind_jalr) ? {resolve_target[31:1], 1'b0}
                                                    : resolve_target;

    assign is_br     = (resolve_kind == kind_br);
    assign wrong_dir = (rec_taken != resolve_taken);

    // a taken miss has no usable target
    assign wrong_target = resolve_taken && (!rec_hit || (rec_target != eff_target));

    assign mispredict = resolve_en && (wrong_dir || wrong_target);

    assign btb_write = resolve_en && resolve_taken;

    // history and phts train on conditional branches only
    assign history_shift = resolve_en && is_br;
    assign pht_inc       = history_shift && resolve_taken;
    assign pht_dec       = history_shift && !resolve_taken;

    // chooser moves only when the two predictors disagreed
    assign pr_differ    = (rec_local_pr != rec_global_pr);
    assign global_right = (rec_global_pr == resolve_taken);
    assign chooser_inc  = history_shift && pr_differ && global_right;
    assign chooser_dec  = history_shift && pr_differ && !global_right;

    always_comb begin
        count_ctrl     = resolve_en; // every control-flow instruction
        count_no_stall = mispredict ? 1'b0 : resolve_en;
        count_correct  = history_shift && !wrong_dir;
    end

endmodule : resolve_unit

`default_nettype wire

// File: perf_counter.sv
`timescale 1ns/100ps
`default_nettype none

module perf_counter
    import bp_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  count,
    output logic [PERF_WIDTH-1:0] value,
    output logic                  overflow
);

    always_ff @(posedge clk) begin
        if (rst) begin
            value    <= '0;
            overflow <= 1'b0;
        end else if (count) begin
            value <= value + 1'b1;
            if (&value) begin
                overflow <= 1'b1; // sticky until reset
            end
        end
    end

endmodule : perf_counter

`default_nettype wire

// File: btb.sv
`timescale 1ns/100ps
`default_nettype none

module btb
    import bp_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  word_t        read_pc,
    input  logic         write_en,
    input  word_t        write_pc,
    input  word_t        write_target,
    input  branch_kind_t write_kind,
    output logic         hit,
    output word_t        target,
    output branch_kind_t kind
);

    logic                        valid   [2**BTB_INDEX_BITS];
    logic [31:BTB_INDEX_BITS+2]  tags    [2**BTB_INDEX_BITS];
    word_t                       targets [2**BTB_INDEX_BITS];
    branch_kind_t                kinds   [2**BTB_INDEX_BITS];

    logic [BTB_INDEX_BITS-1:0] read_index;
    logic [BTB_INDEX_BITS-1:0] write_index;

    assign read_index  = read_pc[BTB_INDEX_BITS+1:2];
    assign write_index = write_pc[BTB_INDEX_BITS+1:2];

    assign hit = valid[read_index] && (tags[read_index] == read_pc[31:BTB_INDEX_BITS+2]);

    // payload shows only on a hit
    assign target = hit ? targets[read_index] : '0;
    assign kind   = hit ? kinds[read_index] : kind_br;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**BTB_INDEX_BITS; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid[write_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tags[write_index]    <= write_pc[31:BTB_INDEX_BITS+2]; // evicts older tag
            targets[write_index] <= write_target;
            kinds[write_index]   <= write_kind;
        end
    end

endmodule : btb

`default_nettype wire

// File: local_history_table.sv
`timescale 1ns/100ps
`default_nettype none

module local_history_table
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  word_t                read_pc,
    input  logic                 write_en,
    input  word_t                write_pc,
    input  logic                 taken,
    output logic [HIST_BITS-1:0] history
);

    logic [HIST_BITS-1:0]      hist [2**BHT_INDEX_BITS]; // one shift register per index
    logic [BHT_INDEX_BITS-1:0] read_index;
    logic [BHT_INDEX_BITS-1:0] write_index;

    assign read_index  = read_pc[BHT_INDEX_BITS+1:2];
    assign write_index = write_pc[BHT_INDEX_BITS+1:2];

    assign history = hist[read_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**BHT_INDEX_BITS; i++) begin
                hist[i] <= '0;
            end
        end else if (write_en) begin
            hist[write_index] <= {hist[write_index][HIST_BITS-2:0], taken}; // newest in lsb
        end
    end

endmodule : local_history_table

`default_nettype wire

// File: sat_counter_table.sv
`timescale 1ns/100ps
`default_nettype none

module sat_counter_table
    import bp_pkg::*;
#(
    parameter int index_bits = HIST_BITS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [index_bits-1:0] read_index,
    input  logic [index_bits-1:0] write_index,
    input  logic                  inc,
    input  logic                  dec,
    output logic                  prediction
);

    logic [1:0] ctr [2**index_bits]; // 2-bit saturating counters

    // upper bit is the taken / global decision
    assign prediction = ctr[read_index][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**index_bits; i++) begin
                ctr[i] <= CTR_INIT;
            end
        end else if (inc) begin
            if (ctr[write_index] != 2'b11) begin
                ctr[write_index] <= ctr[write_index] + 2'd1; // saturate at 3
            end
        end else if (dec) begin
            if (ctr[write_index] != 2'b00) begin
                ctr[write_index] <= ctr[write_index] - 2'd1; // saturate at 0
            end
        end
    end

endmodule : sat_counter_table

`default_nettype wire

// File: bp_pkg.sv
`default_nettype none

package bp_pkg;

    // address and target word
    typedef logic [31:0] word_t;

    // kind of control-flow instruction held in the btb
    typedef enum logic [1:0] {
        kind_br   = 2'b00, // conditional branch
        kind_jal  = 2'b01,
        kind_jalr = 2'b10
    } branch_kind_t;

    // global and local history length, also the pht index width
    localparam int HIST_BITS = 6;

    // local history table index, pc[6:2]
    localparam int BHT_INDEX_BITS = 5;

    // chooser index, pc[7:2]
    localparam int CHOOSER_INDEX_BITS = 6;

    // btb index, pc[5:2]; tag is everything above
    localparam int BTB_INDEX_BITS = 4;

    // weakly not taken / weakly local
    localparam logic [1:0] CTR_INIT = 2'b01;

    // performance counter width
    localparam int PERF_WIDTH = 16;

endpackage : bp_pkg

`default_nettype wire
